//--- Makefile
# Verilator simulation of the instruction cache

SIM      = verilator
TOP      = tb_icache
FILELIST = icache.f
SIMFLAGS = --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- cache_array/hit_select.sv
`timescale 1ns/10ps

module hit_select import icache_pkg::*;
(
    // Request fields
    input  tag_t              tag_i,
    input  word_off_t         word_i,

    // Per-way lookup data
    input  tag_t              tags_i [N_WAYS],
    input  logic [N_WAYS-1:0] valids_i,
    input  line_t             lines_i [N_WAYS],

    // Line arriving from memory
    input  line_t             refill_line_i,
    input  logic              refilling_i,

    output logic              hit_o,
    output word_t             word_o
);

    logic [N_WAYS-1:0] way_match;
    way_idx_t          hit_way;
    line_t             src_line;

    // Tag compare, only valid ways count
    always_comb
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            way_match[w] = valids_i[w] && (tags_i[w] == tag_i);
        end
    end

    assign hit_o = |way_match;

    // One-hot match to way number
    always_comb
    begin
        case (way_match)
            4'b0001: hit_way = 2'd0;
            4'b0010: hit_way = 2'd1;
            4'b0100: hit_way = 2'd2;
            4'b1000: hit_way = 2'd3;
            // Multiple matches fall back to way 0
            default: hit_way = 2'd0;
        endcase
    end

    // Refill line wins while it is being written
    assign src_line = refilling_i ? refill_line_i : lines_i[hit_way];

    // Word 0 in the low bits, one rule for every offset
    assign word_o = src_line[word_i * XLEN +: XLEN];

endmodule

//--- cache_array/way_store.sv
`timescale 1ns/10ps

module way_store import icache_pkg::*;
(
    input  logic     clk_i,

    // Read and write set addresses
    input  set_idx_t rd_set_i,
    input  set_idx_t wr_set_i,

    // Write enables and write data
    input  logic     we_i,
    input  logic     valid_we_i,
    input  logic     valid_i,
    input  tag_t     tag_i,
    input  line_t    line_i,

    // Read data
    output tag_t     tag_o,
    output logic     valid_o,
    output line_t    line_o
);

    // Line data, block RAM style
    line_t line_mem [N_SETS];
    line_t line_q;

    // Tag and valid, distributed RAM style
    tag_t  tag_mem [N_SETS];
    logic  valid_mem [N_SETS];

    // ==============================
    // Line and tag writes
    // ==============================

    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            line_mem[wr_set_i] <= line_i;
            tag_mem[wr_set_i]  <= tag_i;
        end
    end

    // Separate port so INIT clears valid without touching data
    always_ff @(posedge clk_i)
    begin
        if (valid_we_i)
        begin
            valid_mem[wr_set_i] <= valid_i;
        end
    end

    // ==============================
    // Reads
    // ==============================

    // Registered line read, ready in the cycle after the address
    always_ff @(posedge clk_i)
    begin
        line_q <= line_mem[rd_set_i];
    end

    assign line_o = line_q;

    // Tag and valid come back in the same cycle
    assign tag_o   = tag_mem[rd_set_i];
    assign valid_o = valid_mem[rd_set_i];

endmodule

//--- common/icache_pkg.sv
package icache_pkg;

    // ==============================
    // Cache geometry
    // ==============================

    // Processor word and address width
    localparam int XLEN           = 32;
    localparam int N_WAYS         = 4;
    localparam int N_SETS         = 64;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = XLEN * WORDS_PER_LINE;

    // Address field widths
    localparam int SET_BITS  = $clog2(N_SETS);
    localparam int WOFF_BITS = $clog2(WORDS_PER_LINE);
    localparam int BYTE_BITS = 2;
    localparam int TAG_W     = XLEN - SET_BITS - WOFF_BITS - BYTE_BITS;

    // ==============================
    // Width types
    // ==============================

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [XLEN-1:0]           addr_t;
    // Word 0 sits in the lowest bits
    typedef logic [LINE_W-1:0]         line_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [SET_BITS-1:0]       set_idx_t;
    typedef logic [$clog2(N_WAYS)-1:0] way_idx_t;
    typedef logic [WOFF_BITS-1:0]      word_off_t;

    // Byte address split into its cache fields, MSB first
    typedef struct packed {
        tag_t                 tag;
        set_idx_t             set_idx;
        word_off_t            word_off;
        logic [BYTE_BITS-1:0] byte_off;
    } fetch_addr_t;

    // Line refill request towards memory
    typedef struct packed {
        logic  strobe;
        addr_t addr;
    } mem_req_t;

    // Cache controller FSM states
    typedef enum logic [1:0] {
        INIT,
        IDLE,
        LOOKUP,
        REFILL
    } ctrl_state_e;

endpackage

//--- dv/mem_model.sv
`timescale 1ns/10ps

module mem_model import icache_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    // Fetch address the processor side is waiting on
    input  addr_t    fetch_addr_i,
    input  mem_req_t m_req_i,
    output line_t    m_data_o,
    output logic     m_ready_o,
    output int       req_count_o,
    output logic     addr_err_o
);

    localparam int DRIVE_DELAY = 1;
    localparam int MAX_LATENCY = 4;

    integer seed;

    // Every word holds the inverse of its own byte address
    function automatic line_t build_line(input addr_t line_addr);
        line_t line;
        line = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++)
        begin
            line[w * XLEN +: XLEN] = ~(line_addr + addr_t'(4 * w));
        end
        return line;
    endfunction

    initial
    begin
        int    latency;
        addr_t line_addr;
        seed        = 32'h6b;
        m_data_o    = '0;
        m_ready_o   = 1'b0;
        req_count_o = 0;
        addr_err_o  = 1'b0;
        forever
        begin
            @(posedge clk_i);
            if (!rst_i && m_req_i.strobe)
            begin
                req_count_o = req_count_o + 1;
                line_addr   = m_req_i.addr;
                // Request must be the pending fetch with offsets cleared
                if (line_addr !== (fetch_addr_i & 32'hFFFF_FFF0))
                begin
                    addr_err_o = 1'b1;
                end
                // 1 to 4 cycles from the strobe to the line
                latency = 1 + ({$random(seed)} % MAX_LATENCY);
                repeat (latency - 1) @(posedge clk_i);
                #DRIVE_DELAY;
                m_data_o  = build_line(line_addr);
                m_ready_o = 1'b1;
                @(posedge clk_i);
                #DRIVE_DELAY;
                m_ready_o = 1'b0;
                m_data_o  = '0;
            end
        end
    end

endmodule

//--- dv/tb_icache.sv
`timescale 1ns/10ps

module tb_icache import icache_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 5;
    localparam int N_TESTS      = 21;
    // Idle, lookup, strobe cycle, up to 4 memory cycles and one spare
    localparam int ROW_CYCLES   = 8;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + N_SETS + N_TESTS * ROW_CYCLES + 10) * CLK_PERIOD;

    logic     clk;
    logic     rst;
    logic     p_strobe;
    addr_t    p_addr;
    word_t    p_data;
    logic     p_ready;
    mem_req_t m_req;
    line_t    m_data;
    logic     m_ready;
    int       req_count;
    logic     addr_err;

    // Stimulus table, one fetch per row
    string    test_name [N_TESTS];
    addr_t    test_addr [N_TESTS];
    logic     test_hit [N_TESTS];
    int       n_rows;

    icache_top DUT (
        .clk_i      (clk),
        .rst_i      (rst),
        .p_strobe_i (p_strobe),
        .p_addr_i   (p_addr),
        .p_data_o   (p_data),
        .p_ready_o  (p_ready),
        .m_req_o    (m_req),
        .m_data_i   (m_data),
        .m_ready_i  (m_ready)
    );

    mem_model u_mem (
        .clk_i        (clk),
        .rst_i        (rst),
        .fetch_addr_i (p_addr),
        .m_req_i      (m_req),
        .m_data_o     (m_data),
        .m_ready_o    (m_ready),
        .req_count_o  (req_count),
        .addr_err_o   (addr_err)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Helpers
    // ==============================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Nothing may leave the cache before the valid walk ends
    task automatic check_quiet(input string stage);
        check_value({stage, " p_ready"}, 32'd0, 32'(p_ready));
        check_value({stage, " m_strobe"}, 32'd0, 32'(m_req.strobe));
    endtask

    task automatic add_row(input string name, input addr_t addr, input logic hit);
        test_name[n_rows] = name;
        test_addr[n_rows] = addr;
        test_hit[n_rows]  = hit;
        n_rows++;
    endtask

    // Cycles counts from the strobe cycle to the ready cycle
    task automatic fetch_word(input addr_t addr, output word_t data, output int cycles);
        p_strobe = 1'b1;
        p_addr   = addr;
        cycles   = 0;
        @(negedge clk);
        while (p_ready !== 1'b1)
        begin
            cycles++;
            @(negedge clk);
        end
        data = p_data;
        @(posedge clk);
        #DRIVE_DELAY;
        p_strobe = 1'b0;
    endtask

    // ==============================
    // Stimulus table
    // ==============================

    task automatic load_table();
        n_rows = 0;
        // Line in set 0x12, first miss then all words hit
        add_row("first_miss", 32'h0000_2120, 1'b0);
        add_row("rehit",      32'h0000_2120, 1'b1);
        add_row("word1",      32'h0000_2124, 1'b1);
        add_row("word2",      32'h0000_2128, 1'b1);
        add_row("word3",      32'h0000_212C, 1'b1);
        // Four tags A to D in set 5 fill ways 0 to 3
        add_row("fill_a",     32'h0000_0050, 1'b0);
        add_row("fill_b",     32'h0000_0458, 1'b0);
        add_row("fill_c",     32'h0000_0854, 1'b0);
        add_row("fill_d",     32'h0000_0C5C, 1'b0);
        add_row("hit_a",      32'h0000_0050, 1'b1);
        add_row("hit_b",      32'h0000_0454, 1'b1);
        add_row("hit_c",      32'h0000_0858, 1'b1);
        add_row("hit_d",      32'h0000_0C50, 1'b1);
        // E replaces A, A back replaces B, B back replaces C
        add_row("evict_e",    32'h0000_1050, 1'b0);
        add_row("hit_e",      32'h0000_1054, 1'b1);
        add_row("refetch_a",  32'h0000_0050, 1'b0);
        add_row("hit_c2",     32'h0000_0850, 1'b1);
        add_row("hit_d2",     32'h0000_0C54, 1'b1);
        add_row("refetch_b",  32'h0000_0450, 1'b0);
        add_row("hit_e2",     32'h0000_105C, 1'b1);
        add_row("hit_a2",     32'h0000_0058, 1'b1);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial
    begin
        int    strobes_before;
        int    cycles;
        word_t word;
        rst         = 1'b1;
        p_strobe    = 1'b0;
        p_addr      = '0;
        load_table();

        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_quiet("reset");
        end
        rst = 1'b0;

        // Valid clear walk, one set per cycle
        for (int c = 0; c < N_SETS; c++)
        begin
            @(negedge clk);
            check_quiet("init");
        end
        @(posedge clk);
        #DRIVE_DELAY;

        for (int t = 0; t < n_rows; t++)
        begin
            strobes_before = req_count;
            fetch_word(test_addr[t], word, cycles);
            check_value({test_name[t], " word"}, ~test_addr[t], word);
            // A miss costs exactly one memory request, a hit none
            check_value({test_name[t], " mem_req"}, test_hit[t] ? 32'd0 : 32'd1,
                        32'(req_count - strobes_before));
            if (test_hit[t])
            begin
                check_value({test_name[t], " latency"}, 32'd1, 32'(cycles));
            end
            check_value({test_name[t], " refill_addr"}, 32'd0, 32'(addr_err));
        end

        $display("All checks passed");
        $finish;
    end

    // Covers every row at the worst miss latency
    initial
    begin
        #(WATCHDOG_NS);
        abort_run("timeout: the cache stopped answering fetch requests");
    end

endmodule

//--- hw/fifo_victim.sv
`timescale 1ns/10ps

module fifo_victim import icache_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  set_idx_t set_i,
    input  logic     advance_i,
    output way_idx_t victim_o
);

    // Round-robin pointer per set, oldest way in that set
    way_idx_t fifo_cnt_q [N_SETS];
    way_idx_t victim_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
            begin
                fifo_cnt_q[s] <= '0;
            end
        end
        else if (advance_i)
        begin
            // Wraps from way 3 back to way 0
            fifo_cnt_q[set_i] <= fifo_cnt_q[set_i] + 1'b1;
        end
    end

    // Victim follows the addressed set one cycle later
    always_ff @(posedge clk_i)
    begin
        victim_q <= fifo_cnt_q[set_i];
    end

    assign victim_o = victim_q;

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,

    // Processor request
    input  logic              p_strobe_i,
    input  addr_t             p_addr_i,

    // Lookup and memory status
    input  logic              hit_i,
    input  logic              m_ready_i,
    input  way_idx_t          victim_i,

    // Storage write controls
    output logic [N_WAYS-1:0] way_we_o,
    output logic [N_WAYS-1:0] valid_we_o,
    output logic              valid_wdata_o,
    output set_idx_t          wr_set_o,
    output logic              refill_done_o,

    // Handshakes
    output logic              p_ready_o,
    output mem_req_t          m_req_o
);

    // Last set visited by the valid clear walk
    localparam set_idx_t LAST_SET = set_idx_t'(N_SETS - 1);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // Valid clear walk position
    set_idx_t init_cnt_q;

    // Memory request registers
    logic  strobe_q;
    addr_t addr_q;

    // Request address fields and its line-aligned form
    fetch_addr_t req;
    fetch_addr_t req_aligned;

    always_comb
    begin
        req                  = fetch_addr_t'(p_addr_i);
        req_aligned          = req;
        // Clear word and byte offsets for a whole-line fetch
        req_aligned.word_off = '0;
        req_aligned.byte_off = '0;
    end

    // ==============================
    // State register and counters
    // ==============================

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q    <= INIT;
            init_cnt_q <= '0;
            strobe_q   <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == INIT)
            begin
                init_cnt_q <= init_cnt_q + 1'b1;
            end
            // One-cycle pulse, lands in the first REFILL cycle
            strobe_q <= (state_q == LOOKUP) && !hit_i;
        end
    end

    // Line address captured on the miss, held through REFILL
    always_ff @(posedge clk_i)
    begin
        if (state_q == LOOKUP)
        begin
            addr_q <= addr_t'(req_aligned);
        end
    end

    // ==============================
    // Next state
    // ==============================

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            INIT:
            begin
                // One set per cycle, requests wait until done
                if (init_cnt_q == LAST_SET)
                begin
                    state_d = IDLE;
                end
            end
            IDLE:
            begin
                if (p_strobe_i)
                begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP:
            begin
                state_d = hit_i ? IDLE : REFILL;
            end
            REFILL:
            begin
                // Slow memory simply stretches this state
                if (m_ready_i)
                begin
                    state_d = IDLE;
                end
            end
            default:
            begin
                state_d = INIT;
            end
        endcase
    end

    // ==============================
    // Outputs
    // ==============================

    always_comb
    begin
        refill_done_o = (state_q == REFILL) && m_ready_i;

        // One-hot victim write during the refill beat
        way_we_o = '0;
        if (refill_done_o)
        begin
            way_we_o[victim_i] = 1'b1;
        end

        // INIT clears every way, refill sets only the victim
        valid_we_o    = (state_q == INIT) ? '1 : way_we_o;
        valid_wdata_o = refill_done_o;
        wr_set_o      = (state_q == INIT) ? init_cnt_q : req.set_idx;

        p_ready_o = ((state_q == LOOKUP) && hit_i) || refill_done_o;

        m_req_o.strobe = strobe_q;
        m_req_o.addr   = addr_q;
    end

endmodule

//--- hw/icache_top.sv
`timescale 1ns/10ps

module icache_top import icache_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,

    // Processor fetch port
    input  logic     p_strobe_i,
    input  addr_t    p_addr_i,
    output word_t    p_data_o,
    output logic     p_ready_o,

    // Memory refill port
    output mem_req_t m_req_o,
    input  line_t    m_data_i,
    input  logic     m_ready_i
);

    // Request address split into tag, set and word fields
    fetch_addr_t p_addr_f;

    // Per-way storage read ports
    tag_t              way_tag [N_WAYS];
    line_t             way_line [N_WAYS];
    logic [N_WAYS-1:0] way_valid;

    // Write controls from the controller
    logic [N_WAYS-1:0] way_we;
    logic [N_WAYS-1:0] valid_we;
    logic              valid_wdata;
    set_idx_t          wr_set;
    logic              refill_done;

    // Lookup results
    way_idx_t victim;
    logic     hit;

    assign p_addr_f = fetch_addr_t'(p_addr_i);

    // ==============================
    // Control and replacement
    // ==============================

    icache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .p_strobe_i    (p_strobe_i),
        .p_addr_i      (p_addr_i),
        .hit_i         (hit),
        .m_ready_i     (m_ready_i),
        .victim_i      (victim),
        .way_we_o      (way_we),
        .valid_we_o    (valid_we),
        .valid_wdata_o (valid_wdata),
        .wr_set_o      (wr_set),
        .refill_done_o (refill_done),
        .p_ready_o     (p_ready_o),
        .m_req_o       (m_req_o)
    );

    // Victim counter advances on the same cycle the line lands
    fifo_victim u_victim (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .set_i     (p_addr_f.set_idx),
        .advance_i (refill_done),
        .victim_o  (victim)
    );

    // ==============================
    // Storage and hit path
    // ==============================

    // Four identical ways, all read at the request set
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        way_store u_way (
            .clk_i      (clk_i),
            .rd_set_i   (p_addr_f.set_idx),
            .wr_set_i   (wr_set),
            .we_i       (way_we[w]),
            .valid_we_i (valid_we[w]),
            .valid_i    (valid_wdata),
            .tag_i      (p_addr_f.tag),
            .line_i     (m_data_i),
            .tag_o      (way_tag[w]),
            .valid_o    (way_valid[w]),
            .line_o     (way_line[w])
        );
    end

    // Refill word bypasses storage while the line is being written
    hit_select u_hit (
        .tag_i         (p_addr_f.tag),
        .word_i        (p_addr_f.word_off),
        .tags_i        (way_tag),
        .valids_i      (way_valid),
        .lines_i       (way_line),
        .refill_line_i (m_data_i),
        .refilling_i   (refill_done),
        .hit_o         (hit),
        .word_o        (p_data_o)
    );

endmodule

//--- icache.f
common/icache_pkg.sv
cache_array/way_store.sv
cache_array/hit_select.sv
hw/fifo_victim.sv
hw/icache_ctrl.sv
hw/icache_top.sv
dv/mem_model.sv
dv/tb_icache.sv
